// ==== Makefile ====
# Verilator flow for the level-zero instruction cache
TOOL      := verilator
FLAGS     := --timing --assert --timescale 1ns/1ps
TOP       := l0_cache_tb
FILELIST  := src.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Some tests failed
PASS_MSG  := All tests passed

SOURCES   := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(TOOL) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The verdict comes from the log, not from the simulator exit status
sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation gave no verdict"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hw/l0_cache.sv ====
/*
  Level-zero instruction cache for a single fetch port.
  Hits return data in the same cycle, misses wait for one line refill.
  Responses are always accepted and arrive in request order, one at a time.
*/
`timescale 1ns/1ps

module l0_cache (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_valid_i,
  input  logic                    enable_prefetching_i,

  // Fetch port
  input  l0_cache_pkg::addr_t     in_addr_i,
  input  logic                    in_valid_i,
  output l0_cache_pkg::word_t     in_data_o,
  output logic                    in_ready_o,

  // Refill request
  output l0_cache_pkg::addr_t     out_req_addr_o,
  output l0_cache_pkg::req_id_t   out_req_id_o,
  output logic                    out_req_valid_o,
  input  logic                    out_req_ready_i,

  // Refill response
  input  l0_cache_pkg::line_t     out_rsp_data_i,
  input  logic                    out_rsp_valid_i
);

  import l0_cache_pkg::*;

  tag_t  [LINE_COUNT-1:0] tags;
  line_t [LINE_COUNT-1:0] data;
  line_sel_t              valid;
  line_sel_t              hit_sel;
  logic                   prefetch_present;
  addr_t                  prefetch_addr;
  logic                   evict;
  tag_t                   evict_tag;

  // Ready as soon as any line hits
  assign in_ready_o = |hit_sel;

  l0_lookup lookup_inst (
    .in_addr_i          (in_addr_i),
    .prefetch_addr_i    (prefetch_addr),
    .tags_i             (tags),
    .valid_i            (valid),
    .data_i             (data),
    .hit_sel_o          (hit_sel),
    .prefetch_present_o (prefetch_present),
    .data_o             (in_data_o)
  );

  l0_line_store line_store_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_valid_i),
    .evict_i     (evict),
    .evict_tag_i (evict_tag),
    .hit_sel_i   (hit_sel),
    .rsp_valid_i (out_rsp_valid_i),
    .rsp_data_i  (out_rsp_data_i),
    .tags_o      (tags),
    .valid_o     (valid),
    .data_o      (data)
  );

  l0_refill_ctrl refill_ctrl_inst (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .in_valid_i           (in_valid_i),
    .in_addr_i            (in_addr_i),
    .enable_prefetching_i (enable_prefetching_i),
    .hit_sel_i            (hit_sel),
    .prefetch_present_i   (prefetch_present),
    .out_req_ready_i      (out_req_ready_i),
    .out_rsp_valid_i      (out_rsp_valid_i),
    .prefetch_addr_o      (prefetch_addr),
    .evict_o              (evict),
    .evict_tag_o          (evict_tag),
    .out_req_valid_o      (out_req_valid_o),
    .out_req_addr_o       (out_req_addr_o),
    .out_req_id_o         (out_req_id_o)
  );

endmodule

// ==== hw/l0_cache_pkg.sv ====
/*
  Geometry and shared types of the level-zero instruction cache.
  Lines are 128 bits, fetch words 32 bits, and the cache holds 4 lines.
  Changing the geometry needs LINE_ALIGN and FETCH_ALIGN kept consistent.
*/
package l0_cache_pkg;

  // ------------------------------
  // Geometry
  // ------------------------------
  localparam int unsigned FETCH_AW    = 32;
  localparam int unsigned FETCH_DW    = 32;
  localparam int unsigned LINE_WIDTH  = 128;
  localparam int unsigned LINE_COUNT  = 4;

  // Byte offset bits within a line and within a word
  localparam int unsigned LINE_ALIGN  = 4;
  localparam int unsigned FETCH_ALIGN = 2;

  localparam int unsigned TAG_WIDTH   = FETCH_AW - LINE_ALIGN;

  // ------------------------------
  // Request IDs
  // ------------------------------
  localparam int unsigned ID_WIDTH    = 2;

  // Demand refill and next-line prefetch
  localparam logic [ID_WIDTH-1:0] ID_REFILL   = 2'd1;
  localparam logic [ID_WIDTH-1:0] ID_PREFETCH = 2'd2;

  // ------------------------------
  // Types
  // ------------------------------
  typedef logic [FETCH_AW-1:0]   addr_t;
  typedef logic [FETCH_DW-1:0]   word_t;
  typedef logic [LINE_WIDTH-1:0] line_t;
  typedef logic [TAG_WIDTH-1:0]  tag_t;

  // One bit per line, one-hot or zero
  typedef logic [LINE_COUNT-1:0] line_sel_t;

  typedef logic [ID_WIDTH-1:0]   req_id_t;

endpackage

// ==== hw/l0_line_store.sv ====
/*
  Tag, valid and data arrays of the cache with round-robin replacement.
  Only one refill may be outstanding, its line is kept in a single
  pending register. Data and tags have no reset, valid bits do.
*/
`timescale 1ns/1ps

module l0_line_store (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  input  logic                                                flush_i,
  input  logic                                                evict_i,
  input  l0_cache_pkg::tag_t                                  evict_tag_i,
  input  l0_cache_pkg::line_sel_t                             hit_sel_i,
  input  logic                                                rsp_valid_i,
  input  l0_cache_pkg::line_t                                 rsp_data_i,
  output l0_cache_pkg::tag_t  [l0_cache_pkg::LINE_COUNT-1:0]  tags_o,
  output l0_cache_pkg::line_sel_t                             valid_o,
  output l0_cache_pkg::line_t [l0_cache_pkg::LINE_COUNT-1:0]  data_o
);

  import l0_cache_pkg::*;

  localparam int unsigned PtrWidth = $clog2(LINE_COUNT);

  tag_t  [LINE_COUNT-1:0] tag_q;
  line_t [LINE_COUNT-1:0] data_q;
  line_sel_t              valid_q;
  line_sel_t              pending_q;
  line_sel_t              victim;

  logic [PtrWidth-1:0] rr_q;
  logic [PtrWidth-1:0] rr_d;
  logic [PtrWidth-1:0] rr_next;
  logic [PtrWidth-1:0] rr_skip;

  assign rr_next = rr_q + 1'b1;
  assign rr_skip = rr_q + 2'd2;

  // ------------------------------
  // Victim choice
  // ------------------------------
  // Never replace the line the current fetch is reading from
  always_comb begin
    victim = line_sel_t'(1) << rr_q;
    rr_d   = rr_q;
    if (evict_i) begin
      if (victim == hit_sel_i) begin
        victim = line_sel_t'(1) << rr_next;
        rr_d   = rr_skip;
      end else begin
        rr_d   = rr_next;
      end
    end
  end

  // ------------------------------
  // Control state
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q    <= '0;
      valid_q <= '0;
    end else begin
      rr_q <= rr_d;
      for (int unsigned i = 0; i < LINE_COUNT; i++) begin
        if (evict_i && victim[i]) begin
          valid_q[i] <= 1'b0;
        end else if (rsp_valid_i && pending_q[i]) begin
          valid_q[i] <= 1'b1;
        end
      end
      // Flush overrides a refill landing in the same cycle
      if (flush_i) begin
        valid_q <= '0;
      end
    end
  end

  // ------------------------------
  // Arrays
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (evict_i) begin
      pending_q <= victim;
    end
    for (int unsigned i = 0; i < LINE_COUNT; i++) begin
      if (evict_i && victim[i]) begin
        tag_q[i] <= evict_tag_i;
      end
      if (rsp_valid_i && pending_q[i]) begin
        data_q[i] <= rsp_data_i;
      end
    end
  end

  assign tags_o  = tag_q;
  assign valid_o = valid_q;
  assign data_o  = data_q;

  // Relies on the lookup producing a one-hot hit vector
  victim_not_hit_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    evict_i |-> (victim & hit_sel_i) == '0)
    else $error("l0_line_store: victim %b overlaps hit line %b", victim, hit_sel_i);

endmodule

// ==== hw/l0_lookup.sv ====
/*
  Fully associative tag compare for the fetch and prefetch addresses.
  Purely combinational. Only valid lines can hit, so lines that are
  waiting for their refill never match.
*/
`timescale 1ns/1ps

module l0_lookup (
  input  l0_cache_pkg::addr_t                                 in_addr_i,
  input  l0_cache_pkg::addr_t                                 prefetch_addr_i,
  input  l0_cache_pkg::tag_t  [l0_cache_pkg::LINE_COUNT-1:0]  tags_i,
  input  l0_cache_pkg::line_sel_t                             valid_i,
  input  l0_cache_pkg::line_t [l0_cache_pkg::LINE_COUNT-1:0]  data_i,
  output l0_cache_pkg::line_sel_t                             hit_sel_o,
  output logic                                                prefetch_present_o,
  output l0_cache_pkg::word_t                                 data_o
);

  import l0_cache_pkg::*;

  tag_t      fetch_tag;
  tag_t      prefetch_tag;
  line_sel_t prefetch_sel;
  line_t     hit_line;

  logic [LINE_ALIGN-FETCH_ALIGN-1:0] word_idx;

  assign fetch_tag    = in_addr_i[FETCH_AW-1:LINE_ALIGN];
  assign prefetch_tag = prefetch_addr_i[FETCH_AW-1:LINE_ALIGN];
  assign word_idx     = in_addr_i[LINE_ALIGN-1:FETCH_ALIGN];

  // ------------------------------
  // Tag compare
  // ------------------------------
  always_comb begin
    for (int unsigned i = 0; i < LINE_COUNT; i++) begin
      hit_sel_o[i]    = valid_i[i] && (tags_i[i] == fetch_tag);
      prefetch_sel[i] = valid_i[i] && (tags_i[i] == prefetch_tag);
    end
  end

  assign prefetch_present_o = |prefetch_sel;

  // ------------------------------
  // Word select
  // ------------------------------
  // AND-OR mux over the lines, the hit vector is at most one-hot
  always_comb begin
    hit_line = '0;
    for (int unsigned i = 0; i < LINE_COUNT; i++) begin
      hit_line |= {LINE_WIDTH{hit_sel_o[i]}} & data_i[i];
    end
  end

  assign data_o = hit_line[word_idx*FETCH_DW +: FETCH_DW];

  // The line store never holds two valid lines with the same tag
  always_comb begin
    hit_onehot_a: assert final ($onehot0(hit_sel_o))
      else $error("l0_lookup: fetch hits more than one line (%b)", hit_sel_o);
  end

endmodule

// ==== hw/l0_refill_ctrl.sv ====
/*
  Miss detection, next-line prefetch and the refill request port.
  At most one refill or prefetch is outstanding. A latched prefetch
  counts as outstanding from the cycle it is latched. Demand goes first.
*/
`timescale 1ns/1ps

module l0_refill_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    in_valid_i,
  input  l0_cache_pkg::addr_t     in_addr_i,
  input  logic                    enable_prefetching_i,
  input  l0_cache_pkg::line_sel_t hit_sel_i,
  input  logic                    prefetch_present_i,
  input  logic                    out_req_ready_i,
  input  logic                    out_rsp_valid_i,
  output l0_cache_pkg::addr_t     prefetch_addr_o,
  output logic                    evict_o,
  output l0_cache_pkg::tag_t      evict_tag_o,
  output logic                    out_req_valid_o,
  output l0_cache_pkg::addr_t     out_req_addr_o,
  output l0_cache_pkg::req_id_t   out_req_id_o
);

  import l0_cache_pkg::*;

  tag_t  fetch_tag;
  tag_t  next_tag;
  addr_t miss_addr;
  addr_t next_addr;

  logic  hit_any;
  logic  miss;
  logic  miss_q;
  logic  evict_miss;
  logic  evict_prefetch;
  logic  pending_q;
  logic  prefetch_gen;
  logic  latch_prefetch;
  logic  pf_valid_q;
  logic  pf_issue;
  addr_t pf_addr_q;

  assign fetch_tag = in_addr_i[FETCH_AW-1:LINE_ALIGN];
  assign next_tag  = fetch_tag + 1'b1;
  assign miss_addr = {fetch_tag, {LINE_ALIGN{1'b0}}};
  assign next_addr = {next_tag, {LINE_ALIGN{1'b0}}};

  // The lookup checks whether the next line is already there
  assign prefetch_addr_o = next_addr;

  // ------------------------------
  // Miss and prefetch detection
  // ------------------------------
  assign hit_any = |hit_sel_i;
  assign miss    = in_valid_i && !hit_any && !pending_q;

  assign prefetch_gen   = enable_prefetching_i && in_valid_i && hit_any &&
                          !prefetch_present_i && !pending_q;
  assign latch_prefetch = prefetch_gen && !pf_valid_q;

  // A miss evicts once, even while its request waits for ready
  assign evict_miss     = miss && !miss_q;
  assign evict_prefetch = latch_prefetch;

  assign evict_o     = evict_miss || evict_prefetch;
  assign evict_tag_o = evict_prefetch ? next_tag : fetch_tag;

  // ------------------------------
  // Request arbitration
  // ------------------------------
  assign out_req_valid_o = miss || pf_valid_q;
  assign out_req_addr_o  = miss ? miss_addr : pf_addr_q;
  assign out_req_id_o    = miss ? ID_REFILL : ID_PREFETCH;

  // Held prefetch goes out only when no demand miss is asking
  assign pf_issue = pf_valid_q && !miss && out_req_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      miss_q     <= 1'b0;
      pending_q  <= 1'b0;
      pf_valid_q <= 1'b0;
    end else begin
      miss_q <= miss;
      if (pending_q) begin
        if (out_rsp_valid_i) begin
          pending_q <= 1'b0;
        end
      end else if ((miss && out_req_ready_i) || latch_prefetch) begin
        pending_q <= 1'b1;
      end
      if (latch_prefetch) begin
        pf_valid_q <= 1'b1;
      end else if (pf_issue) begin
        pf_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (latch_prefetch) begin
      pf_addr_q <= next_addr;
    end
  end

  // ------------------------------
  // Assertions
  // ------------------------------
  req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_req_valid_o && !out_req_ready_i |=>
      out_req_valid_o && $stable(out_req_addr_o) && $stable(out_req_id_o))
    else $error("l0_refill_ctrl: request changed under back-pressure");

  // The line store keeps a single pending line, so a held prefetch owns it
  evict_exclusive_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    evict_miss |-> !pf_valid_q)
    else $error("l0_refill_ctrl: miss evicts while a prefetch is still held");

endmodule

// ==== src.f ====
hw/l0_cache_pkg.sv
hw/l0_lookup.sv
hw/l0_line_store.sv
hw/l0_refill_ctrl.sv
hw/l0_cache.sv
tb/l0_mem_model.sv
tb/l0_cache_tb.sv

// ==== tb/l0_cache_tb.sv ====
/*
  Testbench of the level-zero instruction cache. Directed tests for misses,
  capacity, flush and prefetch, then random fetches in a 256-byte window.
  Concurrent assertions do the checking. Inputs change on falling edges.
*/
`timescale 1ns/1ps

module l0_cache_tb;

  import l0_cache_pkg::*;

  localparam int unsigned CLK_PERIOD       = 20;
  localparam int unsigned RESET_CYCLES     = 16;
  localparam int unsigned CYCLES_PER_FETCH = 200;

  typedef enum logic [1:0] {CHECK_DATA, CHECK_COLD, CHECK_PREFETCHED} fetch_kind_e;

  logic        clk = 1'b0;
  logic        rst_n = 1'b0;
  logic        flush_valid;
  logic        enable_prefetching;
  addr_t       in_addr;
  logic        in_valid;
  word_t       in_data;
  logic        in_ready;
  addr_t       out_req_addr;
  req_id_t     out_req_id;
  logic        out_req_valid;
  logic        out_req_ready;
  line_t       out_rsp_data;
  logic        out_rsp_valid;
  logic        mem_busy;
  fetch_kind_e fetch_kind;
  string       test_name;
  int unsigned fetches_issued = 0;
  int unsigned data_errors = 0;
  int unsigned request_errors = 0;
  int unsigned prefetch_errors = 0;
  logic        accepted_q;
  logic        quiet_q;
  logic        refill_seen_q;
  addr_t       last_prefetch_q;

  always #(CLK_PERIOD / 2) clk = ~clk;

  l0_cache l0_cache_inst (
    .clk_i(clk), .rst_ni(rst_n), .flush_valid_i(flush_valid),
    .enable_prefetching_i(enable_prefetching), .in_addr_i(in_addr), .in_valid_i(in_valid),
    .in_data_o(in_data), .in_ready_o(in_ready), .out_req_addr_o(out_req_addr),
    .out_req_id_o(out_req_id), .out_req_valid_o(out_req_valid),
    .out_req_ready_i(out_req_ready), .out_rsp_data_i(out_rsp_data),
    .out_rsp_valid_i(out_rsp_valid)
  );

  l0_mem_model mem_model_inst (
    .clk_i(clk), .rst_ni(rst_n), .req_valid_i(out_req_valid), .req_addr_i(out_req_addr),
    .req_ready_o(out_req_ready), .rsp_valid_o(out_rsp_valid), .rsp_data_o(out_rsp_data),
    .busy_o(mem_busy)
  );

  function automatic addr_t line_base(input addr_t addr);
    addr_t base;
    base = addr;
    base[LINE_ALIGN-1:0] = '0;
    return base;
  endfunction

  // Memory fills each word with its byte address XOR a fixed pattern
  function automatic word_t expected_word(input addr_t addr);
    addr_t word_addr;
    word_addr = addr;
    word_addr[FETCH_ALIGN-1:0] = '0;
    return word_addr ^ 32'h5a5a0000;
  endfunction

  // ------------------------------
  // Monitors
  // ------------------------------
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      accepted_q      <= 1'b0;
      quiet_q         <= 1'b0;
      refill_seen_q   <= 1'b0;
      last_prefetch_q <= '0;
    end else begin
      accepted_q <= in_valid && in_ready;
      quiet_q    <= !in_valid && !out_req_valid && !mem_busy;
      // Refill seen for the line of the fetch in flight
      if (in_valid && in_ready) begin
        refill_seen_q <= 1'b0;
      end else if (out_req_valid && out_req_ready && out_req_id == ID_REFILL &&
                   out_req_addr == line_base(in_addr)) begin
        refill_seen_q <= 1'b1;
      end
      if (out_req_valid && out_req_ready && out_req_id == ID_PREFETCH) begin
        last_prefetch_q <= out_req_addr;
      end
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------
  data_a: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && in_ready |-> in_data == expected_word(in_addr))
    else begin
      data_errors++;
      $display("ERROR %s: expected %h actual %h", test_name,
               expected_word($sampled(in_addr)), $sampled(in_data));
    end

  cold_refill_a: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && in_ready && fetch_kind == CHECK_COLD |-> refill_seen_q)
    else begin
      request_errors++;
      $display("ERROR %s: fetch of %h completed without a refill request for its line",
               test_name, $sampled(in_addr));
    end

  prefetched_a: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && in_ready && fetch_kind == CHECK_PREFETCHED |->
      !refill_seen_q && last_prefetch_q == line_base(in_addr))
    else begin
      prefetch_errors++;
      $display("ERROR %s: expected prefetch %h actual %h, refill sent %b", test_name,
               line_base($sampled(in_addr)), $sampled(last_prefetch_q),
               $sampled(refill_seen_q));
    end

  req_aligned_a: assert property (@(posedge clk) disable iff (!rst_n)
    out_req_valid |-> out_req_addr[LINE_ALIGN-1:0] == '0)
    else begin
      request_errors++;
      $display("ERROR %s: request address %h is not line-aligned", test_name,
               $sampled(out_req_addr));
    end

  req_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
    out_req_valid && !out_req_ready |=>
      out_req_valid && $stable(out_req_addr) && $stable(out_req_id))
    else begin
      request_errors++;
      $display("ERROR %s: request was dropped or changed while stalled", test_name);
    end

  no_prefetch_a: assert property (@(posedge clk) disable iff (!rst_n)
    !enable_prefetching |-> !(out_req_valid && out_req_id == ID_PREFETCH))
    else begin
      prefetch_errors++;
      $display("ERROR %s: prefetch request sent while prefetching is disabled", test_name);
    end

  // ------------------------------
  // Stimulus
  // ------------------------------
  // Called at a falling edge, returns at the falling edge after the transfer
  task automatic fetch_word(input addr_t addr, input fetch_kind_e kind);
    in_addr    = addr;
    in_valid   = 1'b1;
    fetch_kind = kind;
    fetches_issued++;
    do begin
      @(negedge clk);
    end while (!accepted_q);
    in_valid   = 1'b0;
    fetch_kind = CHECK_DATA;
  endtask

  // No fetch, no request and no refill in flight
  task automatic wait_idle();
    do begin
      @(negedge clk);
    end while (!quiet_q);
  endtask

  task automatic pulse_flush();
    flush_valid = 1'b1;
    @(negedge clk);
    flush_valid = 1'b0;
  endtask

  initial begin : stimulus
    int unsigned total;
    void'($urandom(32'hb3da));
    flush_valid        = 1'b0;
    enable_prefetching = 1'b0;
    in_addr            = '0;
    in_valid           = 1'b0;
    fetch_kind         = CHECK_DATA;
    test_name          = "reset";
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    test_name = "miss_request";
    fetch_word(32'h1000_0004, CHECK_COLD);
    fetch_word(32'h1000_000c, CHECK_DATA);
    fetch_word(32'h1000_0028, CHECK_COLD);

    // Five lines through four entries push the first one out
    test_name = "capacity";
    for (int unsigned i = 0; i < 5; i++) begin
      fetch_word(32'h2000_0000 + i * 16, CHECK_COLD);
    end
    fetch_word(32'h2000_0008, CHECK_COLD);

    test_name = "flush";
    fetch_word(32'h3000_0040, CHECK_COLD);
    fetch_word(32'h3000_0044, CHECK_DATA);
    wait_idle();
    pulse_flush();
    fetch_word(32'h3000_0048, CHECK_COLD);

    test_name = "prefetch";
    wait_idle();
    enable_prefetching = 1'b1;
    fetch_word(32'h4000_0100, CHECK_COLD);
    fetch_word(32'h4000_0114, CHECK_PREFETCHED);

    test_name = "random";
    for (int unsigned i = 0; i < 40; i++) begin
      fetch_word(32'h5000_0000 + ($urandom % 64) * 4, CHECK_DATA);
    end
    wait_idle();
    enable_prefetching = 1'b0;
    for (int unsigned i = 0; i < 12; i++) begin
      fetch_word(32'h5000_0000 + ($urandom % 64) * 4, CHECK_DATA);
    end
    wait_idle();
    repeat (4) @(negedge clk);

    total = data_errors + request_errors + prefetch_errors;
    $display("Error counts: data %0d, request %0d, prefetch %0d", data_errors,
             request_errors, prefetch_errors);
    if (total == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Budget grows with every fetch issued
  initial begin : watchdog
    int unsigned cycles;
    cycles = 0;
    while (cycles <= RESET_CYCLES + CYCLES_PER_FETCH * (fetches_issued + 1)) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run stalled after %0d cycles and %0d fetches", cycles, fetches_issued);
    $display("Some tests failed");
    $finish;
  end

endmodule

// ==== tb/l0_mem_model.sv ====
/*
  Next-level memory for the cache refill port, one request at a time.
  Ready and response delay are random. Each word of a line holds its byte
  address XOR 32'h5a5a0000. Outputs change on falling clock edges only.
*/
`timescale 1ns/1ps

module l0_mem_model (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_valid_i,
  input  l0_cache_pkg::addr_t req_addr_i,
  output logic                req_ready_o,
  output logic                rsp_valid_o,
  output l0_cache_pkg::line_t rsp_data_o,
  output logic                busy_o
);

  import l0_cache_pkg::*;

  logic        taken_q;
  addr_t       addr_q;
  logic        busy_q = 1'b0;
  logic        ready_q = 1'b0;
  logic        rsp_valid_q = 1'b0;
  line_t       rsp_data_q = '0;
  int unsigned delay_q;

  function automatic line_t build_line(input addr_t base);
    line_t line;
    for (int unsigned i = 0; i < LINE_WIDTH / FETCH_DW; i++) begin
      line[i*FETCH_DW +: FETCH_DW] = (base + i * (FETCH_DW / 8)) ^ 32'h5a5a0000;
    end
    return line;
  endfunction

  // Capture on the rising edge, where the cache samples too
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      taken_q <= 1'b0;
    end else begin
      taken_q <= req_valid_i && req_ready_o;
      if (req_valid_i && req_ready_o) begin
        addr_q <= req_addr_i;
      end
    end
  end

  always @(negedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      = 1'b0;
      ready_q     = 1'b0;
      rsp_valid_q = 1'b0;
      delay_q     = 0;
    end else begin
      rsp_valid_q = 1'b0;
      if (taken_q) begin
        busy_q  = 1'b1;
        delay_q = $urandom % 6;
      end else if (busy_q && delay_q == 0) begin
        rsp_valid_q = 1'b1;
        rsp_data_q  = build_line(addr_q);
        busy_q      = 1'b0;
      end else if (busy_q) begin
        delay_q = delay_q - 1;
      end
      // Back-pressure on about one cycle in three
      ready_q = !busy_q && ($urandom % 3 != 0);
    end
  end

  assign req_ready_o = ready_q;
  assign rsp_valid_o = rsp_valid_q;
  assign rsp_data_o  = rsp_data_q;
  assign busy_o      = busy_q;

endmodule
